/* src.f */
+incdir+design
design/dcache_mem_pkg.sv
design/dcache_line_pkg.sv
design/dcache_array.sv
design/dcache_lru.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := src.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := No errors

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/dcache_tb.sv */
// testbench for the write-through data cache
// shadow memory and LRU residency model with checks at each done
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tb
    import dcache_mem_pkg::*;
();

    // lane, store, eviction and reload requests before the random run
    localparam int DIRECTED_TRANSACTIONS = 36;
    localparam int RANDOM_TRANSACTIONS   = 60;
    localparam int NUM_TRANSACTIONS      = DIRECTED_TRANSACTIONS + RANDOM_TRANSACTIONS;
    localparam int TIMEOUT_CYCLES        = 200 * NUM_TRANSACTIONS;

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       load_valid;
    logic                       store_valid;
    logic [`ADDR_BITS-1:0]      addr;
    mem_size_t                  mem_size;
    logic [31:0]                store_value;
    logic                       done;
    logic [31:0]                load_value;
    bus_command_t               mem_command;
    logic [`BUS_ADDR_BITS-1:0]  mem_addr;
    logic [63:0]                mem_data;
    mem_size_t                  mem_size_out;
    logic [2:0]                 mem_offset;
    logic [3:0]                 mem_response;
    logic                       mem_data_valid;
    logic [3:0]                 mem_tag;
    logic [63:0]                mem_rdata;
    int                         load_count;
    int                         store_count;
    logic [31:0]                last_load_addr;
    logic [63:0]                last_store_data;

    integer                       seed = 32'ha3ed_01f7;
    int                           error_count = 0;
    int                           cycle_count = 0;
    logic [7:0]                   shadow [65536];
    // resident blocks from least to most recently touched
    logic [`BLOCK_ADDR_BITS-1:0]  recency [$];

    dcache_top i_dcache_top (.*);

    dcache_mem_model #(.SEED(32'ha3ed_01f7)) i_mem_model (.mem_size(mem_size_out), .*);

    bind dcache_ctrl dcache_chk i_dcache_chk (
        .clock, .reset, .mem_command, .mem_response, .done, .fill_en, .write_en
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic report_error(string message);
        error_count++;
        $display("ERROR %0t: %s", $time, message);
    endtask

    function automatic int resident_pos(logic [`BLOCK_ADDR_BITS-1:0] block);
        foreach (recency[i]) begin
            if (recency[i] == block) begin
                return i;
            end
        end
        return -1;
    endfunction

    // hit or fill moves a block to the back and a full set drops its front
    task automatic touch_block(logic [`BLOCK_ADDR_BITS-1:0] block);
        int pos;
        pos = resident_pos(block);
        if (pos >= 0) begin
            recency.delete(pos);
        end else if (recency.size() == `CACHE_LINES) begin
            recency.delete(0);
        end
        recency.push_back(block);
    endtask

    // zero-extended little-endian lanes
    function automatic logic [31:0] shadow_value(logic [15:0] a, mem_size_t size);
        case (size)
            MEM_BYTE: return {24'b0, shadow[a]};
            MEM_HALF: return {16'b0, shadow[a + 16'd1], shadow[a]};
            default:  return {shadow[a + 16'd3], shadow[a + 16'd2], shadow[a + 16'd1], shadow[a]};
        endcase
    endfunction

    function automatic logic [63:0] shadow_block(logic [15:0] a);
        logic [63:0] block;
        for (int i = 0; i < 8; i++) begin
            block[8*i +: 8] = shadow[{a[15:3], 3'(i)}];
        end
        return block;
    endfunction

    // block as the memory model holds it now
    function automatic logic [63:0] memory_block(logic [15:0] a);
        logic [63:0] block;
        for (int i = 0; i < 8; i++) begin
            block[8*i +: 8] = i_mem_model.storage[{a[15:3], 3'(i)}];
        end
        return block;
    endfunction

    function automatic logic [15:0] random_addr(logic [15:0] base, int blocks, mem_size_t size);
        int block;
        int offset;
        block  = {$random(seed)} % blocks;
        offset = {$random(seed)} % 8;
        offset = offset & ~((1 << int'(size)) - 1);
        return base + 16'(block * 8 + offset);
    endfunction

    // inputs held through the done cycle
    task automatic run_request(logic is_load, logic [15:0] a, mem_size_t size,
                               logic [31:0] value, output int latency);
        @(posedge clock);
        #1;
        load_valid  = is_load;
        store_valid = !is_load;
        addr        = a;
        mem_size    = size;
        store_value = value;
        latency     = 0;
        do begin
            @(posedge clock);
            #1;
            latency++;
        end while (!done);
    endtask

    task automatic check_load(logic [15:0] a, mem_size_t size);
        logic [31:0] expected;
        logic        resident;
        int          loads_before;
        int          latency;
        expected     = shadow_value(a, size);
        resident     = resident_pos(a[15:3]) >= 0;
        loads_before = load_count;
        run_request(1'b1, a, size, 32'b0, latency);
        assert (load_value == expected) else
            report_error($sformatf("load %h %s returned %h, expected %h",
                                   a, size.name(), load_value, expected));
        assert (load_count - loads_before == (resident ? 0 : 1)) else
            report_error($sformatf("load %h made %0d memory loads, resident %0b",
                                   a, load_count - loads_before, resident));
        if (resident) begin
            assert (latency == 1) else
                report_error($sformatf("load hit %h took %0d cycles", a, latency));
        end else begin
            assert (last_load_addr == {16'b0, a[15:3], 3'b0}) else
                report_error($sformatf("fill for %h went to %h", a, last_load_addr));
        end
        touch_block(a[15:3]);
    endtask

    task automatic check_store(logic [15:0] a, mem_size_t size, logic [31:0] value);
        logic resident;
        int   stores_before;
        int   latency;
        resident      = resident_pos(a[15:3]) >= 0;
        stores_before = store_count;
        for (int i = 0; i < (1 << int'(size)); i++) begin
            shadow[a + 16'(i)] = value[8*i +: 8];
        end
        run_request(1'b0, a, size, value, latency);
        assert (store_count - stores_before == 1) else
            report_error($sformatf("store %h made %0d memory stores",
                                   a, store_count - stores_before));
        // written lanes, address and size as memory saw them
        assert (memory_block(a) == shadow_block(a)) else
            report_error($sformatf("store %h left memory block %h, expected %h",
                                   a, memory_block(a), shadow_block(a)));
        if (resident) begin
            assert (last_store_data == shadow_block(a)) else
                report_error($sformatf("store hit %h wrote %h, expected %h",
                                       a, last_store_data, shadow_block(a)));
            touch_block(a[15:3]);
        end
    endtask

    initial begin
        logic [`BLOCK_ADDR_BITS-1:0] snapshot [$];
        logic [15:0]                 a;
        mem_size_t                   size;
        load_valid  = 1'b0;
        store_valid = 1'b0;
        addr        = '0;
        mem_size    = MEM_BYTE;
        store_value = 32'b0;
        reset       = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = i_mem_model.storage[i];
        end

        ////////////////////
        // cold miss then every lane hits
        ////////////////////
        check_load(16'h1004, MEM_WORD);
        for (int i = 0; i < 8; i++) begin
            check_load(16'h1000 + 16'(i), MEM_BYTE);
        end
        for (int i = 0; i < 8; i += 2) begin
            check_load(16'h1000 + 16'(i), MEM_HALF);
        end
        check_load(16'h1000, MEM_WORD);

        // store hit merges while a store miss only writes through
        check_store(16'h1002, MEM_HALF, $random(seed));
        check_load(16'h1000, MEM_WORD);
        check_store(16'h1808, MEM_WORD, $random(seed));
        check_load(16'h1808, MEM_WORD);

        ////////////////////
        // nine fills then the eviction check
        ////////////////////
        for (int i = 0; i < 9; i++) begin
            check_load(16'h2000 + 16'(8 * i), MEM_WORD);
        end
        check_load(16'h2000, MEM_WORD);
        snapshot = recency;
        foreach (snapshot[i]) begin
            check_load({snapshot[i], 3'b0}, MEM_WORD);
        end

        // random traffic over twelve blocks
        for (int n = 0; n < RANDOM_TRANSACTIONS; n++) begin
            size = mem_size_t'({$random(seed)} % 3);
            a    = random_addr(16'h3000, 12, size);
            if ($random(seed) & 1) begin
                check_store(a, size, $random(seed));
            end else begin
                check_load(a, size);
            end
        end

        @(posedge clock);
        #1;
        load_valid  = 1'b0;
        store_valid = 1'b0;
        repeat (4) @(posedge clock);
        error_count += i_dcache_top.i_dcache_ctrl.i_dcache_chk.failures;
        $display("error count: %0d", error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tests/dcache_chk.sv */
// protocol checks for the data cache controller
`timescale 1ns/100ps

module dcache_chk
    import dcache_mem_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  bus_command_t mem_command,
    input  logic [3:0]   mem_response,
    input  logic         done,
    input  logic         fill_en,
    input  logic         write_en
);

    int failures = 0;

    // a command waits unchanged for its response
    command_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command != BUS_NONE && mem_response == 4'b0) |=> $stable(mem_command))
    else begin
        failures++;
        $error("memory command changed before it was accepted");
    end

    done_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else begin
        failures++;
        $error("done stayed high for more than one cycle");
    end

    fill_or_write: assert property (@(posedge clock) disable iff (reset) !(fill_en && write_en))
    else begin
        failures++;
        $error("fill and store write enabled in the same cycle");
    end

    idle_after_reset: assert property (@(posedge clock) reset |=> mem_command == BUS_NONE)
    else begin
        failures++;
        $error("memory command active right after reset");
    end

endmodule

/* tests/dcache_mem_model.sv */
// tagged memory model for the data cache testbench
// random acceptance and data delays, byte-masked stores
`timescale 1ns/100ps

module dcache_mem_model
    import dcache_mem_pkg::*;
#(
    parameter int SEED = 1
) (
    input  logic         clock,
    input  logic         reset,
    input  bus_command_t mem_command,
    input  logic [31:0]  mem_addr,
    input  logic [63:0]  mem_data,
    input  mem_size_t    mem_size,
    input  logic [2:0]   mem_offset,
    output logic [3:0]   mem_response,
    output logic         mem_data_valid,
    output logic [3:0]   mem_tag,
    output logic [63:0]  mem_rdata,
    output int           load_count,
    output int           store_count,
    output logic [31:0]  last_load_addr,
    output logic [63:0]  last_store_data
);

    logic [7:0]  storage [65536];
    integer      seed = SEED;
    int          accept_wait;
    int          data_wait;
    logic        data_pending;
    logic [3:0]  pending_tag;
    logic [3:0]  next_tag;
    logic [15:0] pending_base;

    // fill pattern mixes both address bytes
    initial begin
        for (int a = 0; a < 65536; a++) begin
            storage[a] = 8'(a * 37) ^ 8'(a >> 8) ^ 8'h5a;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            mem_response    <= 4'b0;
            mem_data_valid  <= 1'b0;
            mem_tag         <= 4'b0;
            mem_rdata       <= 64'b0;
            data_pending    <= 1'b0;
            next_tag        <= 4'd1;
            accept_wait     <= 0;
            load_count      <= 0;
            store_count     <= 0;
            last_load_addr  <= 32'b0;
            last_store_data <= 64'b0;
        end else begin
            mem_response   <= 4'b0;
            mem_data_valid <= 1'b0;
            // accept after a random wait, one command at a time
            if (mem_command != BUS_NONE && mem_response == 4'b0) begin
                if (accept_wait > 0) begin
                    accept_wait <= accept_wait - 1;
                end else begin
                    mem_response <= next_tag;
                    next_tag     <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    accept_wait  <= $random(seed) & 3;
                    if (mem_command == BUS_LOAD) begin
                        load_count     <= load_count + 1;
                        last_load_addr <= mem_addr;
                        data_pending   <= 1'b1;
                        pending_tag    <= next_tag;
                        pending_base   <= mem_addr[15:0];
                        data_wait      <= $random(seed) & 3;
                    end else begin
                        store_count     <= store_count + 1;
                        last_store_data <= mem_data;
                        for (int i = 0; i < 8; i++) begin
                            if ((mem_size == MEM_BYTE && 3'(i) == mem_offset) ||
                                (mem_size == MEM_HALF && 2'(i >> 1) == mem_offset[2:1]) ||
                                (mem_size == MEM_WORD && 1'(i >> 2) == mem_offset[2])) begin
                                storage[mem_addr[15:0] + 16'(i)] <= mem_data[8*i +: 8];
                            end
                        end
                    end
                end
            end
            // load data returns later under its tag
            if (data_pending) begin
                if (data_wait > 0) begin
                    data_wait <= data_wait - 1;
                end else begin
                    mem_data_valid <= 1'b1;
                    mem_tag        <= pending_tag;
                    data_pending   <= 1'b0;
                    for (int i = 0; i < 8; i++) begin
                        mem_rdata[8*i +: 8] <= storage[pending_base + 16'(i)];
                    end
                end
            end
        end
    end

endmodule

/* design/dcache_top.sv */
// write-through data cache, eight fully associative lines
// between the load/store queue and the tagged memory port
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_top
    import dcache_mem_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    // load/store queue side
    input  logic                       load_valid,
    input  logic                       store_valid,
    input  logic [`ADDR_BITS-1:0]      addr,
    input  mem_size_t                  mem_size,
    input  logic [31:0]                store_value,
    output logic                       done,
    output logic [31:0]                load_value,
    // memory side
    output bus_command_t               mem_command,
    output logic [`BUS_ADDR_BITS-1:0]  mem_addr,
    output logic [63:0]                mem_data,
    output mem_size_t                  mem_size_out,
    output logic [2:0]                 mem_offset,
    input  logic [3:0]                 mem_response,
    input  logic                       mem_data_valid,
    input  logic [3:0]                 mem_tag,
    input  logic [63:0]                mem_rdata
);

    logic                       hit;
    logic [`LINE_IDX_BITS-1:0]  hit_index;
    logic [63:0]                merged_block;
    logic [`LINE_IDX_BITS-1:0]  victim_index;
    logic                       write_en;
    logic                       fill_en;
    logic [`LINE_IDX_BITS-1:0]  fill_index;
    logic [63:0]                fill_block;
    logic                       touch;
    logic [`LINE_IDX_BITS-1:0]  touch_index;

    // byte lanes for the memory-side write mask
    assign mem_size_out = mem_size;
    assign mem_offset   = addr[2:0];

    dcache_ctrl i_dcache_ctrl (
        .clock, .reset, .load_valid, .store_valid, .addr, .hit, .merged_block,
        .victim_index, .mem_response, .mem_data_valid, .mem_tag, .mem_rdata,
        .mem_command, .mem_addr, .mem_data, .write_en, .fill_en, .fill_index,
        .fill_block, .done
    );

    dcache_array i_dcache_array (
        .clock, .reset, .lookup_addr(addr), .mem_size, .store_value, .write_en,
        .fill_en, .fill_index, .fill_block, .hit, .hit_index, .load_value,
        .merged_block, .touch, .touch_index
    );

    dcache_lru i_dcache_lru (
        .clock, .reset, .touch, .touch_index, .victim_index
    );

endmodule

/* design/dcache_ctrl.sv */
// request sequencer for the data cache
// drives the tagged memory port for fills and write-through
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl
    import dcache_mem_pkg::*;
    import dcache_line_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load_valid,
    input  logic                        store_valid,
    input  logic [`ADDR_BITS-1:0]       addr,
    input  logic                        hit,
    input  cache_block_t                merged_block,
    input  logic [`LINE_IDX_BITS-1:0]   victim_index,
    input  logic [3:0]                  mem_response,
    input  logic                        mem_data_valid,
    input  logic [3:0]                  mem_tag,
    input  cache_block_t                mem_rdata,
    output bus_command_t                mem_command,
    output logic [`BUS_ADDR_BITS-1:0]   mem_addr,
    output logic [63:0]                 mem_data,
    output logic                        write_en,
    output logic                        fill_en,
    output logic [`LINE_IDX_BITS-1:0]   fill_index,
    output cache_block_t                fill_block,
    output logic                        done
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_ISSUE     = 3'd1;
    localparam logic [2:0] S_WAIT_DATA = 3'd2;
    localparam logic [2:0] S_FILL      = 3'd3;
    localparam logic [2:0] S_FINISH    = 3'd4;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       is_store;
    logic [3:0] pending_tag;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        next_state  = state;
        mem_command = BUS_NONE;
        write_en    = 1'b0;
        fill_en     = 1'b0;
        done        = 1'b0;
        case (state)
            S_IDLE: begin
                if (load_valid) begin
                    next_state = hit ? S_FINISH : S_ISSUE;
                end else if (store_valid) begin
                    // hit line takes the store on entry
                    write_en   = hit;
                    next_state = S_ISSUE;
                end
            end
            S_ISSUE: begin
                mem_command = is_store ? BUS_STORE : BUS_LOAD;
                if (mem_response != 4'b0) begin
                    next_state = is_store ? S_FINISH : S_WAIT_DATA;
                end
            end
            S_WAIT_DATA: begin
                if (mem_data_valid && mem_tag == pending_tag) begin
                    fill_en    = 1'b1;
                    next_state = S_FILL;
                end
            end
            S_FILL: begin
                // lookup replays against the filled line
                if (hit) begin
                    done       = 1'b1;
                    next_state = S_IDLE;
                end else begin
                    next_state = S_ISSUE;
                end
            end
            S_FINISH: begin
                done       = 1'b1;
                next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

    assign mem_addr   = {{(`BUS_ADDR_BITS - `ADDR_BITS){1'b0}}, addr[`ADDR_BITS-1:3], 3'b000};
    assign mem_data   = is_store ? merged_block.double_level : 64'b0;
    assign fill_index = victim_index;
    assign fill_block = mem_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= S_IDLE;
            is_store    <= 1'b0;
            pending_tag <= 4'b0;
        end else begin
            state <= next_state;
            if (state == S_IDLE && (load_valid || store_valid)) begin
                is_store <= !load_valid;
            end
            // acceptance latches the outstanding tag
            if (state == S_ISSUE && mem_response != 4'b0) begin
                pending_tag <= mem_response;
            end
        end
    end

endmodule

/* design/dcache_lru.sv */
// age counters for the data cache lines
// picks the least recently touched line as victim
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_lru (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       touch,
    input  logic [`LINE_IDX_BITS-1:0]  touch_index,
    output logic [`LINE_IDX_BITS-1:0]  victim_index
);

    localparam logic [`LINE_IDX_BITS-1:0] AGE_MAX = '1;

    logic [`LINE_IDX_BITS-1:0] age [`CACHE_LINES];
    logic [`LINE_IDX_BITS-1:0] old_age;
    logic                      found;

    assign old_age = age[touch_index];

    // touched line to the top, younger lines step down
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                age[i] <= '0;
            end
        end else if (touch) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                if (`LINE_IDX_BITS'(i) == touch_index) begin
                    age[i] <= AGE_MAX;
                end else if (age[i] > old_age) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
        end
    end

    // lowest line at age zero, unused lines first
    always_comb begin
        found        = 1'b0;
        victim_index = '0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            if (!found && age[i] == '0) begin
                found        = 1'b1;
                victim_index = `LINE_IDX_BITS'(i);
            end
        end
    end

endmodule

/* design/dcache_array.sv */
// fully associative line storage for the data cache
// lookup, load lane extraction, store merge and fill
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_array
    import dcache_mem_pkg::*;
    import dcache_line_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`ADDR_BITS-1:0]      lookup_addr,
    input  mem_size_t                  mem_size,
    input  logic [31:0]                store_value,
    input  logic                       write_en,
    input  logic                       fill_en,
    input  logic [`LINE_IDX_BITS-1:0]  fill_index,
    input  cache_block_t               fill_block,
    output logic                       hit,
    output logic [`LINE_IDX_BITS-1:0]  hit_index,
    output logic [31:0]                load_value,
    output cache_block_t               merged_block,
    output logic                       touch,
    output logic [`LINE_IDX_BITS-1:0]  touch_index
);

    cache_line_t                    lines [`CACHE_LINES];
    logic [`BLOCK_ADDR_BITS-1:0]    lookup_block;
    cache_block_t                   hit_block;

    assign lookup_block = lookup_addr[`ADDR_BITS-1:3];

    ////////////////////
    // lookup
    ////////////////////
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            if (!hit && lines[i].valid && lines[i].block_addr == lookup_block) begin
                hit       = 1'b1;
                hit_index = `LINE_IDX_BITS'(i);
            end
        end
        hit_block = hit ? lines[hit_index].data : '0;
    end

    // zero-extended load lanes
    always_comb begin
        case (mem_size)
            MEM_BYTE: load_value = {24'b0, hit_block.byte_level[lookup_addr[2:0]]};
            MEM_HALF: load_value = {16'b0, hit_block.half_level[lookup_addr[2:1]]};
            MEM_WORD: load_value = hit_block.word_level[lookup_addr[2]];
            default:  load_value = 32'b0;
        endcase
    end

    // store lanes over the hit line, or over zero on a miss
    always_comb begin
        merged_block = hit_block;
        case (mem_size)
            MEM_BYTE: merged_block.byte_level[lookup_addr[2:0]] = store_value[7:0];
            MEM_HALF: merged_block.half_level[lookup_addr[2:1]] = store_value[15:0];
            MEM_WORD: merged_block.word_level[lookup_addr[2]]   = store_value;
            default:  merged_block = hit_block;
        endcase
    end

    // repeated touches of one line leave the ages unchanged
    assign touch       = fill_en | hit;
    assign touch_index = fill_en ? fill_index : hit_index;

    ////////////////////
    // line update
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (fill_en) begin
            lines[fill_index].valid      <= 1'b1;
            lines[fill_index].block_addr <= lookup_block;
            lines[fill_index].data       <= fill_block;
        end else if (write_en && hit) begin
            lines[hit_index].data <= merged_block;
        end
    end

endmodule

/* design/dcache_line_pkg.sv */
// storage types for the data cache
// one 64-bit block per line, seen at four access widths
`include "dcache_defs.svh"

package dcache_line_pkg;

    // same block read as bytes, halves, words or one double
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
        logic [63:0]      double_level;
    } cache_block_t;

    typedef struct packed {
        logic                          valid;
        logic [`BLOCK_ADDR_BITS-1:0]   block_addr;
        cache_block_t                  data;
    } cache_line_t;

endpackage

/* design/dcache_mem_pkg.sv */
// memory-side types for the data cache
// bus command and access size encodings
package dcache_mem_pkg;

    // command toward the tagged memory port
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    // access width of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE = 2'h0,
        MEM_HALF = 2'h1,
        MEM_WORD = 2'h2
    } mem_size_t;

endpackage

/* design/dcache_defs.svh */
// data cache geometry and address widths
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

////////////////////
// line storage
////////////////////
`define CACHE_LINES     8
`define LINE_IDX_BITS   3

////////////////////
// addressing
////////////////////
`define ADDR_BITS       16
`define BUS_ADDR_BITS   32
// byte address minus the 3 offset bits
`define BLOCK_ADDR_BITS 13

`endif
